// File: rtl/socPkg.sv
`default_nettype none

package socPkg;

    // bus geometry
    localparam int addrWidth = 16;
    localparam int dataWidth = 32;
    localparam int byteLanes = dataWidth / 8;
    localparam int maxTimers = 8;

    // region code lives in the top address nibble
    localparam int regionLsb = 12;
    localparam int regionWidth = addrWidth - regionLsb;
    localparam logic [regionWidth-1:0] regionRam = 4'd0;
    localparam logic [regionWidth-1:0] regionTimer = 4'd1;
    localparam logic [regionWidth-1:0] regionIntc = 4'd2;

    // timers are packed 16 bytes apart from 0x1000
    localparam int timerStride = 16;
    localparam logic [addrWidth-1:0] timerControlOffset = 16'h0;
    localparam logic [addrWidth-1:0] timerReloadOffset = 16'h4;
    localparam logic [addrWidth-1:0] timerCountOffset = 16'h8;

    // interrupt controller registers
    localparam logic [addrWidth-1:0] intcPendingOffset = 16'h0;
    localparam logic [addrWidth-1:0] intcMaskOffset = 16'h4;

    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [byteLanes-1:0]  byteEnable;
        logic [addrWidth-1:0]  address;
        logic [dataWidth-1:0]  writeData;
    } busRequestT;

    typedef struct packed {
        logic                  valid;
        logic [dataWidth-1:0]  data;
    } readResponseT;

    // enable in bit 0, autoReload in bit 1
    typedef struct packed {
        logic [dataWidth-3:0]  reserved;
        logic                  autoReload;
        logic                  enable;
    } timerControlT;

    // same write word, seen as reload value or as control fields
    typedef union packed {
        logic [dataWidth-1:0]  value;
        timerControlT          control;
    } timerWordT;

endpackage

`default_nettype wire

// File: rtl/busDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module busDecoder #(
    parameter int numTimers = 3
)(
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire socPkg::busRequestT  request,
    output socPkg::busRequestT       ramRequest,
    output socPkg::busRequestT       timerRequest [numTimers],
    output socPkg::busRequestT       intcRequest,
    output logic                     unmappedRead
);

    import socPkg::*;

    // timer index sits between the stride bits and the region code
    localparam int strideBits = $clog2(timerStride);
    localparam int indexWidth = regionLsb - strideBits;

    logic [regionWidth-1:0]  region;
    logic [indexWidth-1:0]   timerIndex;
    logic                    isRam;
    logic                    isTimer;
    logic                    isIntc;

    // strobes and target selects, cleared by reset
    logic                    readQ;
    logic                    writeQ;
    logic                    ramSelQ;
    logic                    intcSelQ;
    logic [numTimers-1:0]    timerSelQ;
    logic                    unmappedReadQ;

    // payload of the request held for one cycle
    logic [byteLanes-1:0]    byteEnableQ;
    logic [addrWidth-1:0]    addressQ;
    logic [dataWidth-1:0]    writeDataQ;

    if (numTimers < 1 || numTimers > maxTimers) begin : gBadTimerCount
        $error("busDecoder numTimers must be from 1 to maxTimers");
    end

    assign region = request.address[addrWidth-1:regionLsb];
    assign timerIndex = request.address[regionLsb-1:strideBits];
    assign isRam = region == regionRam;
    assign isIntc = region == regionIntc;
    // timer slots past numTimers fall into unmapped space
    assign isTimer = region == regionTimer && timerIndex < numTimers;

    always_ff @(posedge clk) begin
        if (reset) begin
            readQ <= 1'b0;
            writeQ <= 1'b0;
            ramSelQ <= 1'b0;
            intcSelQ <= 1'b0;
            timerSelQ <= '0;
            unmappedReadQ <= 1'b0;
        end else begin
            readQ <= request.read;
            writeQ <= request.write;
            ramSelQ <= isRam;
            intcSelQ <= isIntc;
            for (int i = 0; i < numTimers; i++) begin
                timerSelQ[i] <= isTimer && timerIndex == indexWidth'(i);
            end
            // unmapped writes just vanish
            unmappedReadQ <= request.read && !isRam && !isIntc && !isTimer;
        end
    end

    always_ff @(posedge clk) begin
        byteEnableQ <= request.byteEnable;
        addressQ <= request.address;
        writeDataQ <= request.writeData;
    end

    // strobes only reach the selected target, address cut to its offset
    always_comb begin
        ramRequest = '{readQ && ramSelQ, writeQ && ramSelQ, byteEnableQ,
                       addrWidth'(addressQ[regionLsb-1:0]), writeDataQ};
        intcRequest = '{readQ && intcSelQ, writeQ && intcSelQ, byteEnableQ,
                        addrWidth'(addressQ[regionLsb-1:0]), writeDataQ};
        for (int i = 0; i < numTimers; i++) begin
            timerRequest[i] = '{readQ && timerSelQ[i], writeQ && timerSelQ[i], byteEnableQ,
                                addrWidth'(addressQ[strideBits-1:0]), writeDataQ};
        end
    end

    assign unmappedRead = unmappedReadQ;

    // master never reads and writes in one cycle
    assert property (@(posedge clk) disable iff (reset) !(request.read && request.write));

endmodule

`default_nettype wire

// File: rtl/scratchRam.sv
`timescale 1ns/1ps
`default_nettype none

module scratchRam #(
    parameter int ramWords = 1024
)(
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire socPkg::busRequestT  ramRequest,
    output socPkg::readResponseT     ramResponse
);

    import socPkg::*;

    // word index spans the region offset above the byte bits
    localparam int indexWidth = regionLsb - 2;

    logic [dataWidth-1:0]   memory [ramWords];
    logic [indexWidth-1:0]  wordIndex;
    logic                   readValidQ;
    logic [dataWidth-1:0]   readDataQ;

    // addresses wrap when the RAM is smaller than the region
    assign wordIndex = indexWidth'(ramRequest.address[regionLsb-1:2] % ramWords);

    // per-lane writes
    always_ff @(posedge clk) begin
        if (ramRequest.write) begin
            for (int lane = 0; lane < byteLanes; lane++) begin
                if (ramRequest.byteEnable[lane]) begin
                    memory[wordIndex][lane*8 +: 8] <= ramRequest.writeData[lane*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ramRequest.read) begin
            readDataQ <= memory[wordIndex];
        end
    end

    // valid one cycle after the read strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            readValidQ <= 1'b0;
        end else begin
            readValidQ <= ramRequest.read;
        end
    end

    assign ramResponse = '{readValidQ, readDataQ};

endmodule

`default_nettype wire

// File: rtl/intervalTimer.sv
`timescale 1ns/1ps
`default_nettype none

module intervalTimer (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire socPkg::busRequestT  timerRequest,
    output socPkg::readResponseT     timerResponse,
    output logic                     expire
);

    import socPkg::*;

    timerControlT          controlQ;
    logic [dataWidth-1:0]  reloadQ;
    logic [dataWidth-1:0]  countQ;
    timerWordT             writeWord;
    logic                  writeControl;
    logic                  writeReload;
    logic                  tick;
    logic                  lastTick;
    logic [dataWidth-1:0]  readData;
    logic                  readValidQ;
    logic [dataWidth-1:0]  readDataQ;

    assign writeWord.value = timerRequest.writeData;
    assign writeControl = timerRequest.write && timerRequest.address == timerControlOffset;
    assign writeReload = timerRequest.write && timerRequest.address == timerReloadOffset;

    // a stopped count of zero never ticks
    assign tick = controlQ.enable && countQ != '0;
    assign lastTick = tick && countQ == dataWidth'(1);

    always_ff @(posedge clk) begin
        if (reset) begin
            controlQ <= '0;
            reloadQ <= '0;
            countQ <= '0;
            expire <= 1'b0;
        end else begin
            expire <= lastTick;
            if (lastTick) begin
                if (controlQ.autoReload) begin
                    countQ <= reloadQ;
                end else begin
                    // one-shot stops at zero
                    countQ <= '0;
                    controlQ.enable <= 1'b0;
                end
            end else if (tick) begin
                countQ <= countQ - 1'b1;
            end
            // software writes win over counting
            if (writeControl) begin
                controlQ <= '{'0, writeWord.control.autoReload, writeWord.control.enable};
            end
            if (writeReload) begin
                reloadQ <= writeWord.value;
                countQ <= writeWord.value;
            end
        end
    end

    always_comb begin
        case (timerRequest.address)
            timerControlOffset: readData = controlQ;
            timerReloadOffset:  readData = reloadQ;
            timerCountOffset:   readData = countQ;
            default:            readData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            readValidQ <= 1'b0;
        end else begin
            readValidQ <= timerRequest.read;
        end
    end

    always_ff @(posedge clk) begin
        readDataQ <= readData;
    end

    assign timerResponse = '{readValidQ, readDataQ};

    // expiry only ever follows a count of one
    assert property (@(posedge clk) disable iff (reset) expire |-> $past(countQ) == dataWidth'(1));

endmodule

`default_nettype wire

// File: rtl/interruptController.sv
`timescale 1ns/1ps
`default_nettype none

module interruptController #(
    parameter int numTimers = 3
)(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire socPkg::busRequestT    intcRequest,
    input  wire logic [numTimers-1:0]  timerEvents,
    output socPkg::readResponseT       intcResponse,
    output logic                       interruptRequest
);

    import socPkg::*;

    logic [numTimers-1:0]  pendingQ;
    logic [numTimers-1:0]  maskQ;
    logic                  writePending;
    logic                  writeMask;
    logic [dataWidth-1:0]  readData;
    logic                  readValidQ;
    logic [dataWidth-1:0]  readDataQ;

    assign writePending = intcRequest.write && intcRequest.address == intcPendingOffset;
    assign writeMask = intcRequest.write && intcRequest.address == intcMaskOffset;

    always_ff @(posedge clk) begin
        if (reset) begin
            pendingQ <= '0;
            maskQ <= '0;
        end else begin
            // write-one-to-clear, a fresh event in the same cycle stays set
            if (writePending) begin
                pendingQ <= (pendingQ & ~intcRequest.writeData[numTimers-1:0]) | timerEvents;
            end else begin
                pendingQ <= pendingQ | timerEvents;
            end
            if (writeMask) begin
                maskQ <= intcRequest.writeData[numTimers-1:0];
            end
        end
    end

    // registers read back zero-extended
    always_comb begin
        case (intcRequest.address)
            intcPendingOffset: readData = dataWidth'(pendingQ);
            intcMaskOffset:    readData = dataWidth'(maskQ);
            default:           readData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            readValidQ <= 1'b0;
        end else begin
            readValidQ <= intcRequest.read;
        end
    end

    always_ff @(posedge clk) begin
        readDataQ <= readData;
    end

    assign intcResponse = '{readValidQ, readDataQ};
    assign interruptRequest = |(pendingQ & maskQ);

endmodule

`default_nettype wire

// File: rtl/readReturnMux.sv
`timescale 1ns/1ps
`default_nettype none

module readReturnMux #(
    parameter int numTimers = 3
)(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire socPkg::readResponseT  ramResponse,
    input  wire socPkg::readResponseT  timerResponse [numTimers],
    input  wire socPkg::readResponseT  intcResponse,
    input  wire logic                  unmappedRead,
    output socPkg::readResponseT       response
);

    import socPkg::*;

    logic                  unmappedReadQ;
    logic [numTimers-1:0]  timerValid;
    logic [dataWidth-1:0]  timerData;

    // lines the unmapped pulse up with the one-cycle peripheral reads
    always_ff @(posedge clk) begin
        if (reset) begin
            unmappedReadQ <= 1'b0;
        end else begin
            unmappedReadQ <= unmappedRead;
        end
    end

    // gather the timer array
    always_comb begin
        timerValid = '0;
        timerData = '0;
        for (int i = 0; i < numTimers; i++) begin
            timerValid[i] = timerResponse[i].valid;
            if (timerResponse[i].valid) begin
                timerData |= timerResponse[i].data;
            end
        end
    end

    // only valid sources contribute, an unmapped read adds no data bits
    always_comb begin
        response.valid = ramResponse.valid || intcResponse.valid || |timerValid || unmappedReadQ;
        response.data = timerData;
        if (ramResponse.valid) begin
            response.data |= ramResponse.data;
        end
        if (intcResponse.valid) begin
            response.data |= intcResponse.data;
        end
    end

    // decoder routes each request to one target, so returns never collide
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({ramResponse.valid, intcResponse.valid, timerValid, unmappedReadQ}));

endmodule

`default_nettype wire

// File: rtl/peripheralSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module peripheralSubsystem #(
    parameter int ramWords  = 1024,
    parameter int numTimers = 3
)(
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire socPkg::busRequestT  request,
    output socPkg::readResponseT     response,
    output logic                     interruptRequest
);

    import socPkg::*;

    // routed requests
    busRequestT            ramRequest;
    busRequestT            timerRequest [numTimers];
    busRequestT            intcRequest;
    logic                  unmappedRead;

    // per-target read returns
    readResponseT          ramResponse;
    readResponseT          timerResponse [numTimers];
    readResponseT          intcResponse;

    // one expire line per timer
    logic [numTimers-1:0]  timerEvents;


    busDecoder #(.numTimers(numTimers))
    busDecoder(
        .clk,
        .reset,
        .request,
        .ramRequest,
        .timerRequest,
        .intcRequest,
        .unmappedRead
    );


    scratchRam #(.ramWords(ramWords))
    scratchRam(
        .clk,
        .reset,
        .ramRequest,
        .ramResponse
    );


    // timer i answers at 0x1000 plus 16 times i
    for (genvar i = 0; i < numTimers; i++) begin : gTimer
        intervalTimer
        intervalTimer(
            .clk,
            .reset,
            .timerRequest           (timerRequest[i]),
            .timerResponse          (timerResponse[i]),
            .expire                 (timerEvents[i])
        );
    end


    interruptController #(.numTimers(numTimers))
    interruptController(
        .clk,
        .reset,
        .intcRequest,
        .timerEvents,
        .intcResponse,
        .interruptRequest
    );


    readReturnMux #(.numTimers(numTimers))
    readReturnMux(
        .clk,
        .reset,
        .ramResponse,
        .timerResponse,
        .intcResponse,
        .unmappedRead,
        .response
    );

endmodule

`default_nettype wire

// File: tests/tbPeripheralSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tbPeripheralSubsystem;

    import socPkg::*;

    // watchdog budget
    localparam int numTests = 5;
    localparam int timerCyclesWaited = 120;
    localparam int timeoutNs = numTests * 200 + timerCyclesWaited * 40;

    logic          clk;
    logic          reset;
    busRequestT    request;
    readResponseT  response;
    logic          interruptRequest;

    int            errorCount;
    int            passCount;
    int            failCount;
    // address list and returned data for back-to-back reads
    logic [addrWidth-1:0]  burstAddr [8];
    logic [dataWidth-1:0]  burstData [8];

    peripheralSubsystem #(.ramWords(1024), .numTimers(3)) DUT (
        .clk,
        .reset,
        .request,
        .response,
        .interruptRequest
    );

    always #2 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    // every bus task starts and ends 1 ns after a rising edge
    task automatic busWrite(input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] lanes);
        request = '{read: 1'b0, write: 1'b1, byteEnable: lanes, address: addr,
                    writeData: data};
        @(posedge clk);
        #1;
        request = '0;
        @(posedge clk);
        #1;
    endtask

    // reads on consecutive cycles, each valid expected two edges later
    task automatic readBurst(input int count);
        for (int k = 0; k < count + 2; k++) begin
            if (k < count) begin
                request = '{read: 1'b1, write: 1'b0, byteEnable: 4'hF,
                            address: burstAddr[k], writeData: '0};
            end else begin
                request = '0;
            end
            // sampled mid-cycle, away from the edge
            @(negedge clk);
            if (k >= 2) begin
                burstData[k-2] = response.data;
                if (!response.valid) begin
                    $display("no read response two edges after the read of %h",
                             burstAddr[k-2]);
                    errorCount++;
                end
            end else if (response.valid) begin
                $display("read response arrived earlier than two edges");
                errorCount++;
            end
            @(posedge clk);
            #1;
        end
        @(negedge clk);
        if (response.valid) begin
            $display("read response valid lasted more than one cycle");
            errorCount++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic busRead(input logic [15:0] addr, output logic [31:0] data);
        burstAddr[0] = addr;
        readBurst(1);
        data = burstData[0];
    endtask

    task automatic waitForIrq(input logic level, input int maxCycles);
        bit seen;
        seen = 1'b0;
        for (int cycle = 0; cycle < maxCycles && !seen; cycle++) begin
            @(negedge clk);
            seen = interruptRequest === level;
            @(posedge clk);
            #1;
        end
        if (!seen) begin
            $display("interruptRequest did not reach %0b within %0d cycles", level, maxCycles);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("test %s passed", name);
        end else begin
            failCount++;
            $display("test %s failed with %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    task automatic resetState();
        int errorsBefore;
        logic [31:0] data;
        errorsBefore = errorCount;
        @(negedge clk);
        checkValue("response.valid", 32'h0, response.valid);
        checkValue("interruptRequest", 32'h0, interruptRequest);
        @(posedge clk);
        #1;
        busRead(16'h2000, data);
        checkValue("pending", 32'h0, data);
        busRead(16'h2004, data);
        checkValue("mask", 32'h0, data);
        // count register of each timer
        for (int i = 0; i < 3; i++) begin
            busRead(16'h1008 + 16'(i * timerStride), data);
            checkValue($sformatf("timer%0d count", i), 32'h0, data);
        end
        reportTest("reset state", errorsBefore);
    endtask

    task automatic ramAccess();
        int errorsBefore;
        logic [31:0] expected [6];
        logic [31:0] data;
        errorsBefore = errorCount;
        burstAddr[0] = 16'h0000;
        burstAddr[1] = 16'h0004;
        burstAddr[2] = 16'h0008;
        burstAddr[3] = 16'h0100;
        burstAddr[4] = 16'h0ffc;
        burstAddr[5] = 16'h0a40;
        for (int i = 0; i < 6; i++) begin
            expected[i] = $urandom();
            busWrite(burstAddr[i], expected[i], 4'hF);
        end
        readBurst(6);
        for (int i = 0; i < 6; i++) begin
            checkValue($sformatf("ram[%h]", burstAddr[i]), expected[i], burstData[i]);
        end
        // lanes 0 and 2 only
        busWrite(16'h0200, 32'h11223344, 4'hF);
        busWrite(16'h0200, 32'hAABBCCDD, 4'b0101);
        busRead(16'h0200, data);
        // bytes DD and BB land, 11 and 33 stay
        checkValue("ram[0200]", 32'h11BB33DD, data);
        reportTest("ram access", errorsBefore);
    endtask

    task automatic unmappedSpace();
        int errorsBefore;
        errorsBefore = errorCount;
        busWrite(16'h0010, 32'hCAFEF00D, 4'hF);
        // same offset in region 3 must not alias the RAM
        busWrite(16'h3010, 32'hDEADBEEF, 4'hF);
        burstAddr[0] = 16'h3000;
        burstAddr[1] = 16'h1030;
        burstAddr[2] = 16'h0010;
        readBurst(3);
        checkValue("region 3 read", 32'h0, burstData[0]);
        checkValue("timer3 read", 32'h0, burstData[1]);
        checkValue("ram[0010]", 32'hCAFEF00D, burstData[2]);
        reportTest("unmapped space", errorsBefore);
    endtask

    task automatic oneShotTimer();
        int errorsBefore;
        int polls;
        timerWordT word;
        logic [31:0] data;
        errorsBefore = errorCount;
        word.value = '0;
        word.control.enable = 1'b1;
        busWrite(16'h1014, 32'd20, 4'hF);
        busWrite(16'h1010, word.value, 4'hF);
        polls = 0;
        data = 32'hFFFF_FFFF;
        while (data != 0 && polls < 16) begin
            busRead(16'h1018, data);
            polls++;
        end
        if (data != 0) begin
            $display("timer1 count never reached zero");
            errorCount++;
        end
        busRead(16'h2000, data);
        checkValue("pending", 32'h2, data);
        busRead(16'h1010, data);
        checkValue("timer1 control", 32'h0, data);
        checkValue("interruptRequest", 32'h0, interruptRequest);
        // leave pending clean for the next test
        busWrite(16'h2000, 32'h2, 4'hF);
        busRead(16'h2000, data);
        checkValue("pending", 32'h0, data);
        reportTest("one-shot timer", errorsBefore);
    endtask

    task automatic autoReloadMask();
        int errorsBefore;
        timerWordT word;
        logic [31:0] data;
        errorsBefore = errorCount;
        word.value = '0;
        word.control.enable = 1'b1;
        word.control.autoReload = 1'b1;
        busWrite(16'h2004, 32'h1, 4'hF);
        busWrite(16'h1004, 32'd8, 4'hF);
        busWrite(16'h1000, word.value, 4'hF);
        waitForIrq(1'b1, 40);
        // period of 8 leaves room to clear and read before the next expiry
        busWrite(16'h2000, 32'h1, 4'hF);
        busRead(16'h2000, data);
        checkValue("pending", 32'h0, data);
        waitForIrq(1'b1, 12);
        busWrite(16'h2004, 32'h0, 4'hF);
        waitForIrq(1'b0, 4);
        busRead(16'h2000, data);
        checkValue("pending", 32'h1, data);
        checkValue("interruptRequest", 32'h0, interruptRequest);
        reportTest("auto-reload and mask", errorsBefore);
    endtask

    // watchdog
    initial begin
        #(timeoutNs);
        $display("timeout after %0d ns, tests did not finish", timeoutNs);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        void'($urandom(31837));
        clk = 1'b0;
        reset = 1'b1;
        request = '0;
        errorCount = 0;
        passCount = 0;
        failCount = 0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        resetState();
        ramAccess();
        unmappedSpace();
        oneShotTimer();
        autoReloadMask();
        $display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
rtl/socPkg.sv
rtl/busDecoder.sv
rtl/scratchRam.sv
rtl/intervalTimer.sv
rtl/interruptController.sv
rtl/readReturnMux.sv
rtl/peripheralSubsystem.sv
tests/tbPeripheralSubsystem.sv
